// File: Makefile
# Verilator build and run for the pipelined core testbench

VERILATOR ?= verilator
TOP       ?= coreTb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

PASS_MSG := Result: PASSED
SOURCES  := $(shell grep -v '^+' $(FILELIST))
BIN      := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

$(LOG): $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -qx '$(PASS_MSG)' $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

check: $(LOG)
	@grep -qx '$(PASS_MSG)' $(LOG) || { echo "No passing run in $(LOG)"; exit 1; }
	@echo "Log $(LOG) shows a passing run"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim.f
source/armPkg.sv
source/regFile.sv
source/alu.sv
source/controller.sv
source/hazardUnit.sv
source/datapath.sv
source/armCore.sv
verification/coreTb.sv

// File: source/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
  input  logic [31:0]          a,
  input  logic [31:0]          b,
  input  armPkg::aluOpT        op,
  output logic [31:0]          result,
  output logic [3:0]           flags
);

  logic        isSub;
  logic [31:0] bEff;
  logic [32:0] sum;
  logic        negative;
  logic        zero;
  logic        carry;
  logic        overflow;

  // Subtract as a + ~b + 1
  assign isSub = (op == armPkg::aluSub);
  assign bEff  = isSub ? ~b : b;
  assign sum   = {1'b0, a} + {1'b0, bEff} + {32'h0, isSub};

  always_comb begin
    case (op)
      armPkg::aluAdd,
      armPkg::aluSub: begin
        result = sum[31:0];
      end
      armPkg::aluAnd: begin
        result = a & b;
      end
      armPkg::aluOrr: begin
        result = a | b;
      end
      armPkg::aluPassB: begin
        result = b;
      end
      default: begin
        result = 32'h0;
      end
    endcase
  end

  assign negative = result[31];
  assign zero     = (result == 32'h0);

  // Carry out means no borrow on subtract
  assign carry = (op == armPkg::aluAdd || isSub) && sum[32];

  // Operands of equal sign giving a result of the other sign
  assign overflow = (op == armPkg::aluAdd || isSub) &&
                    (a[31] == bEff[31]) && (sum[31] != a[31]);

  assign flags = {negative, zero, carry, overflow};

endmodule

`default_nettype wire

// File: source/armCore.sv
`timescale 1ns/100ps
`default_nettype none

module armCore (
  input  logic         clk,
  input  logic         rstN,
  output logic [31:0]  instrAddr,
  input  logic [31:0]  instr,
  output logic [31:0]  dataAddr,
  output logic [31:0]  writeData,
  output logic         memWrite,
  input  logic [31:0]  readData
);

  logic [31:0]      instrD;
  logic [3:0]       aluFlagsE;
  logic [1:0]       regSrcD;
  armPkg::immSrcT   immSrcD;
  armPkg::aluOpT    aluOpE;
  armPkg::fwdSelT   forwardAE, forwardBE;
  logic             aluSrcE, branchTakenE, memtoRegE, memtoRegW;
  logic             regWriteM, regWriteW;
  logic             stallF, stallD, flushD, flushE;
  logic             match1EM, match1EW, match2EM, match2EW, match12DE;

  controller i_controller (
    .clk(clk), .rstN(rstN), .instrD(instrD), .aluFlagsE(aluFlagsE), .flushE(flushE),
    .regSrcD(regSrcD), .immSrcD(immSrcD), .aluSrcE(aluSrcE), .aluOpE(aluOpE),
    .branchTakenE(branchTakenE), .memWrite(memWrite), .memtoRegE(memtoRegE),
    .memtoRegW(memtoRegW), .regWriteM(regWriteM), .regWriteW(regWriteW)
  );

  datapath i_datapath (
    .clk(clk), .rstN(rstN), .instrAddr(instrAddr), .instr(instr), .instrD(instrD),
    .regSrcD(regSrcD), .immSrcD(immSrcD), .aluSrcE(aluSrcE), .aluOpE(aluOpE),
    .aluFlagsE(aluFlagsE), .branchTakenE(branchTakenE), .memtoRegW(memtoRegW),
    .regWriteW(regWriteW), .dataAddr(dataAddr), .writeData(writeData),
    .readData(readData), .forwardAE(forwardAE), .forwardBE(forwardBE),
    .stallF(stallF), .stallD(stallD), .flushD(flushD), .flushE(flushE),
    .match1EM(match1EM), .match1EW(match1EW), .match2EM(match2EM),
    .match2EW(match2EW), .match12DE(match12DE)
  );

  hazardUnit i_hazardUnit (
    .match1EM(match1EM), .match1EW(match1EW), .match2EM(match2EM),
    .match2EW(match2EW), .match12DE(match12DE), .regWriteM(regWriteM),
    .regWriteW(regWriteW), .memtoRegE(memtoRegE), .branchTakenE(branchTakenE),
    .forwardAE(forwardAE), .forwardBE(forwardBE), .stallF(stallF),
    .stallD(stallD), .flushD(flushD), .flushE(flushE)
  );

endmodule

`default_nettype wire

// File: source/armPkg.sv
`default_nettype none

package armPkg;

  // Register file geometry
  localparam int regAddrWidth = 4;

  // Fetch address after reset
  localparam logic [31:0] resetPc = 32'h0000_0000;

  // ALU operations issued by the controller
  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOrr,
    aluPassB
  } aluOpT;

  // Immediate formats in Decode
  typedef enum logic [1:0] {
    immRot,
    immMem,
    immBranch
  } immSrcT;

  // Operand sources in Execute
  typedef enum logic [1:0] {
    fwdReg,
    fwdResultW,
    fwdAluOutM
  } fwdSelT;

  // Condition field, bits 31:28 of every instruction
  typedef logic [3:0] condT;

  localparam condT condEq = 4'b0000;
  localparam condT condNe = 4'b0001;
  localparam condT condGe = 4'b1010;
  localparam condT condLt = 4'b1011;
  localparam condT condAl = 4'b1110;

  // Op field, bits 27:26
  localparam logic [1:0] opData   = 2'b00;
  localparam logic [1:0] opMem    = 2'b01;
  localparam logic [1:0] opBranch = 2'b10;

  // Data-processing cmd field, bits 24:21
  localparam logic [3:0] cmdAnd = 4'b0000;
  localparam logic [3:0] cmdSub = 4'b0010;
  localparam logic [3:0] cmdAdd = 4'b0100;
  localparam logic [3:0] cmdCmp = 4'b1010;
  localparam logic [3:0] cmdOrr = 4'b1100;
  localparam logic [3:0] cmdMov = 4'b1101;

endpackage

`default_nettype wire

// File: source/controller.sv
`timescale 1ns/100ps
`default_nettype none

module controller (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic [31:0]          instrD,
  input  logic [3:0]           aluFlagsE,
  input  logic                 flushE,
  output logic [1:0]           regSrcD,
  output armPkg::immSrcT       immSrcD,
  output logic                 aluSrcE,
  output armPkg::aluOpT        aluOpE,
  output logic                 branchTakenE,
  output logic                 memWrite,
  output logic                 memtoRegE,
  output logic                 memtoRegW,
  output logic                 regWriteM,
  output logic                 regWriteW
);

  logic [1:0]      opD;
  logic [3:0]      cmdD;
  logic            regWriteD, memWriteD, memtoRegD, branchD, flagWriteD, aluSrcD;
  armPkg::aluOpT   aluOpD;
  logic            regWriteE, memWriteE, branchE, flagWriteE;
  armPkg::condT    condE;
  logic [3:0]      flags;
  logic            condExE;
  logic            memtoRegM;

  assign opD  = instrD[27:26];
  assign cmdD = instrD[24:21];

  // Decode
  always_comb begin
    regWriteD  = 1'b0;
    memWriteD  = 1'b0;
    memtoRegD  = 1'b0;
    branchD    = 1'b0;
    flagWriteD = 1'b0;
    aluSrcD    = 1'b0;
    aluOpD     = armPkg::aluAdd;
    immSrcD    = armPkg::immRot;
    regSrcD    = 2'b00;
    case (opD)
      armPkg::opData: begin
        aluSrcD    = instrD[25];
        regWriteD  = (cmdD != armPkg::cmdCmp);
        flagWriteD = (cmdD == armPkg::cmdCmp);
        case (cmdD)
          armPkg::cmdAdd: aluOpD = armPkg::aluAdd;
          armPkg::cmdSub, armPkg::cmdCmp: aluOpD = armPkg::aluSub;
          armPkg::cmdAnd: aluOpD = armPkg::aluAnd;
          armPkg::cmdOrr: aluOpD = armPkg::aluOrr;
          armPkg::cmdMov: aluOpD = armPkg::aluPassB;
          default: regWriteD = 1'b0;
        endcase
      end
      armPkg::opMem: begin
        // L bit picks load or store, stores read Rd on port 2
        aluSrcD   = 1'b1;
        immSrcD   = armPkg::immMem;
        regWriteD = instrD[20];
        memtoRegD = instrD[20];
        memWriteD = ~instrD[20];
        regSrcD   = {~instrD[20], 1'b0};
      end
      armPkg::opBranch: begin
        // Target is R15 plus the shifted offset
        aluSrcD = 1'b1;
        immSrcD = armPkg::immBranch;
        branchD = 1'b1;
        regSrcD = 2'b01;
      end
      default: begin
        // Op 11 decodes to a bubble
      end
    endcase
  end

  // Decode to Execute
  always_ff @(posedge clk) begin
    if (!rstN || flushE) begin
      regWriteE  <= 1'b0;
      memWriteE  <= 1'b0;
      memtoRegE  <= 1'b0;
      branchE    <= 1'b0;
      flagWriteE <= 1'b0;
    end else begin
      regWriteE  <= regWriteD;
      memWriteE  <= memWriteD;
      memtoRegE  <= memtoRegD;
      branchE    <= branchD;
      flagWriteE <= flagWriteD;
    end
    aluSrcE <= aluSrcD;
    aluOpE  <= aluOpD;
    condE   <= instrD[31:28];
  end

  // Condition check, flags are {N, Z, C, V}
  always_comb begin
    case (condE)
      armPkg::condEq: condExE = flags[2];
      armPkg::condNe: condExE = ~flags[2];
      armPkg::condGe: condExE = (flags[3] == flags[0]);
      armPkg::condLt: condExE = (flags[3] != flags[0]);
      armPkg::condAl: condExE = 1'b1;
      default:        condExE = 1'b0;
    endcase
  end

  assign branchTakenE = branchE & condExE;

  // Only a passing CMP updates the flags
  always_ff @(posedge clk) begin
    if (!rstN) begin
      flags <= 4'h0;
    end else if (flagWriteE && condExE) begin
      flags <= aluFlagsE;
    end
  end

  // Execute to Memory to Writeback
  always_ff @(posedge clk) begin
    if (!rstN) begin
      regWriteM <= 1'b0;
      memWrite  <= 1'b0;
      memtoRegM <= 1'b0;
      regWriteW <= 1'b0;
      memtoRegW <= 1'b0;
    end else begin
      regWriteM <= regWriteE & condExE;
      memWrite  <= memWriteE & condExE;
      memtoRegM <= memtoRegE;
      regWriteW <= regWriteM;
      memtoRegW <= memtoRegM;
    end
  end

endmodule

`default_nettype wire

// File: source/datapath.sv
`timescale 1ns/100ps
`default_nettype none

module datapath (
  input  logic                 clk,
  input  logic                 rstN,
  output logic [31:0]          instrAddr,
  input  logic [31:0]          instr,
  output logic [31:0]          instrD,
  input  logic [1:0]           regSrcD,
  input  armPkg::immSrcT       immSrcD,
  input  logic                 aluSrcE,
  input  armPkg::aluOpT        aluOpE,
  output logic [3:0]           aluFlagsE,
  input  logic                 branchTakenE,
  input  logic                 memtoRegW,
  input  logic                 regWriteW,
  output logic [31:0]          dataAddr,
  output logic [31:0]          writeData,
  input  logic [31:0]          readData,
  input  armPkg::fwdSelT       forwardAE,
  input  armPkg::fwdSelT       forwardBE,
  input  logic                 stallF,
  input  logic                 stallD,
  input  logic                 flushD,
  input  logic                 flushE,
  output logic                 match1EM,
  output logic                 match1EW,
  output logic                 match2EM,
  output logic                 match2EW,
  output logic                 match12DE
);

  localparam int aw = armPkg::regAddrWidth;

  // Op field 11 decodes to no operation
  localparam logic [31:0] bubbleInstr = 32'h0C00_0000;

  logic [31:0]   pcF, pcPlus4F, pcNextF;
  logic [aw-1:0] ra1D, ra2D, ra1E, ra2E;
  logic [aw-1:0] waE, waM, waW;
  logic [31:0]   rd1D, rd2D, extImmD;
  logic [63:0]   immPairD, immShiftD;
  logic [31:0]   rd1E, rd2E, extImmE;
  logic [31:0]   srcAE, writeDataE, srcBE, aluResultE;
  logic [31:0]   aluOutM, aluOutW, readDataW, resultW;

  // Fetch
  assign pcPlus4F  = pcF + 32'd4;
  assign pcNextF   = branchTakenE ? aluResultE : pcPlus4F;
  assign instrAddr = pcF;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pcF <= armPkg::resetPc;
    end else if (!stallF) begin
      pcF <= pcNextF;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN || flushD) begin
      instrD <= bubbleInstr;
    end else if (!stallD) begin
      instrD <= instr;
    end
  end

  // PC+4 of Fetch is PC+8 of the Decode instruction
  assign ra1D = regSrcD[0] ? 4'd15 : instrD[19:16];
  assign ra2D = regSrcD[1] ? instrD[15:12] : instrD[3:0];

  regFile i_regFile (
    .clk     (clk),
    .we      (regWriteW),
    .ra1     (ra1D),
    .ra2     (ra2D),
    .wa      (waW),
    .wd      (resultW),
    .pcPlus8 (pcPlus4F),
    .rd1     (rd1D),
    .rd2     (rd2D)
  );

  // imm8 rotated right by twice the rot field
  assign immPairD  = {24'h0, instrD[7:0], 24'h0, instrD[7:0]};
  assign immShiftD = immPairD >> {instrD[11:8], 1'b0};

  always_comb begin
    case (immSrcD)
      armPkg::immMem:    extImmD = {20'h0, instrD[11:0]};
      armPkg::immBranch: extImmD = {{6{instrD[23]}}, instrD[23:0], 2'b00};
      default:           extImmD = immShiftD[31:0];
    endcase
  end

  // Execute registers load zeros for a bubble
  always_ff @(posedge clk) begin
    if (flushE) begin
      rd1E    <= 32'h0;
      rd2E    <= 32'h0;
      extImmE <= 32'h0;
      ra1E    <= '0;
      ra2E    <= '0;
      waE     <= '0;
    end else begin
      rd1E    <= rd1D;
      rd2E    <= rd2D;
      extImmE <= extImmD;
      ra1E    <= ra1D;
      ra2E    <= ra2D;
      waE     <= instrD[15:12];
    end
  end

  always_comb begin
    case (forwardAE)
      armPkg::fwdResultW: srcAE = resultW;
      armPkg::fwdAluOutM: srcAE = aluOutM;
      default:            srcAE = rd1E;
    endcase
    case (forwardBE)
      armPkg::fwdResultW: writeDataE = resultW;
      armPkg::fwdAluOutM: writeDataE = aluOutM;
      default:            writeDataE = rd2E;
    endcase
  end

  assign srcBE = aluSrcE ? extImmE : writeDataE;

  alu i_alu (
    .a      (srcAE),
    .b      (srcBE),
    .op     (aluOpE),
    .result (aluResultE),
    .flags  (aluFlagsE)
  );

  // Memory
  always_ff @(posedge clk) begin
    aluOutM   <= aluResultE;
    writeData <= writeDataE;
    waM       <= waE;
  end

  assign dataAddr = aluOutM;

  // Writeback
  always_ff @(posedge clk) begin
    aluOutW   <= aluOutM;
    readDataW <= readData;
    waW       <= waM;
  end

  assign resultW = memtoRegW ? readDataW : aluOutW;

  // Register number compares that the hazard unit qualifies
  assign match1EM  = (waM == ra1E);
  assign match1EW  = (waW == ra1E);
  assign match2EM  = (waM == ra2E);
  assign match2EW  = (waW == ra2E);
  assign match12DE = (waE == ra1D) | (waE == ra2D);

endmodule

`default_nettype wire

// File: source/hazardUnit.sv
`timescale 1ns/100ps
`default_nettype none

module hazardUnit (
  input  logic                 match1EM,
  input  logic                 match1EW,
  input  logic                 match2EM,
  input  logic                 match2EW,
  input  logic                 match12DE,
  input  logic                 regWriteM,
  input  logic                 regWriteW,
  input  logic                 memtoRegE,
  input  logic                 branchTakenE,
  output armPkg::fwdSelT       forwardAE,
  output armPkg::fwdSelT       forwardBE,
  output logic                 stallF,
  output logic                 stallD,
  output logic                 flushD,
  output logic                 flushE
);

  logic ldrStall;

  // Memory stage is younger, so it wins over Writeback
  always_comb begin
    if (match1EM && regWriteM) begin
      forwardAE = armPkg::fwdAluOutM;
    end else if (match1EW && regWriteW) begin
      forwardAE = armPkg::fwdResultW;
    end else begin
      forwardAE = armPkg::fwdReg;
    end
  end

  always_comb begin
    if (match2EM && regWriteM) begin
      forwardBE = armPkg::fwdAluOutM;
    end else if (match2EW && regWriteW) begin
      forwardBE = armPkg::fwdResultW;
    end else begin
      forwardBE = armPkg::fwdReg;
    end
  end

  // Load data is not ready until Writeback, hold the consumer one cycle
  assign ldrStall = match12DE & memtoRegE;

  assign stallF = ldrStall;
  assign stallD = ldrStall;

  // Taken branch kills the two younger instructions
  assign flushD = branchTakenE;
  assign flushE = ldrStall | branchTakenE;

endmodule

`default_nettype wire

// File: source/regFile.sv
`timescale 1ns/100ps
`default_nettype none

module regFile (
  input  logic                             clk,
  input  logic                             we,
  input  logic [armPkg::regAddrWidth-1:0]  ra1,
  input  logic [armPkg::regAddrWidth-1:0]  ra2,
  input  logic [armPkg::regAddrWidth-1:0]  wa,
  input  logic [31:0]                      wd,
  input  logic [31:0]                      pcPlus8,
  output logic [31:0]                      rd1,
  output logic [31:0]                      rd2
);

  localparam int numRegs = 2 ** armPkg::regAddrWidth;
  localparam logic [armPkg::regAddrWidth-1:0] pcReg = '1;

  logic [31:0] regs [numRegs];

  always_ff @(posedge clk) begin
    if (we) begin
      regs[wa] <= wd;
    end
  end

  // R15 reads as PC+8, a same-cycle write goes straight to the reader
  always_comb begin
    if (ra1 == pcReg) begin
      rd1 = pcPlus8;
    end else if (we && (wa == ra1)) begin
      rd1 = wd;
    end else begin
      rd1 = regs[ra1];
    end

    if (ra2 == pcReg) begin
      rd2 = pcPlus8;
    end else if (we && (wa == ra2)) begin
      rd2 = wd;
    end else begin
      rd2 = regs[ra2];
    end
  end

endmodule

`default_nettype wire

// File: verification/coreTb.sv
`timescale 1ns/100ps
`default_nettype none

module coreTb;

  localparam int storeTimeout = 400;

  logic        clk;
  logic        rstN;
  logic [31:0] instrAddr, instr, dataAddr, writeData, readData;
  logic        memWrite;

  logic [31:0] imem [256];
  logic [31:0] dmem [256];
  logic [7:0]  progLen;

  logic [31:0] storeAddrQ[$], storeDataQ[$], expAddr[$], expData[$];
  int          storeCycleQ[$];
  int          cycleNum = 0;
  int          errors = 0;
  int          checks = 0;

  armCore i_dut (
    .clk(clk), .rstN(rstN), .instrAddr(instrAddr), .instr(instr),
    .dataAddr(dataAddr), .writeData(writeData), .memWrite(memWrite), .readData(readData)
  );

  // Both memories answer in the same cycle
  assign instr    = imem[instrAddr[9:2]];
  assign readData = dmem[dataAddr[9:2]];

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic fillData();
    int i;
    for (i = 0; i < 256; i++) begin
      dmem[8'(i)] = {~8'(i), 8'(i), 8'hA5 ^ 8'(i), 8'(i)};
    end
  endtask

  // Data memory owner and store log that refresh while in reset
  initial begin
    fillData();
    forever begin
      @(negedge clk);
      cycleNum = cycleNum + 1;
      if (!rstN) begin
        fillData();
        storeAddrQ.delete();
        storeDataQ.delete();
        storeCycleQ.delete();
      end else if (memWrite) begin
        dmem[dataAddr[9:2]] = writeData;
        storeAddrQ.push_back(dataAddr);
        storeDataQ.push_back(writeData);
        storeCycleQ.push_back(cycleNum);
      end
    end
  end

  function automatic logic [31:0] dataImm(input armPkg::condT cond, input logic [3:0] cmd,
      input logic [3:0] rd, input logic [3:0] rn, input logic [3:0] rot, input logic [7:0] imm);
    return {cond, armPkg::opData, 1'b1, cmd, (cmd == armPkg::cmdCmp), rn, rd, rot, imm};
  endfunction

  function automatic logic [31:0] dataReg(input armPkg::condT cond, input logic [3:0] cmd,
      input logic [3:0] rd, input logic [3:0] rn, input logic [3:0] rm);
    return {cond, armPkg::opData, 1'b0, cmd, (cmd == armPkg::cmdCmp), rn, rd, 8'h00, rm};
  endfunction

  // Pre-indexed with the offset added and no writeback
  function automatic logic [31:0] memInstr(input logic load, input logic [3:0] rd,
      input logic [3:0] rn, input logic [11:0] off);
    return {armPkg::condAl, armPkg::opMem, 4'b0110, 1'b0, load, rn, rd, off};
  endfunction

  function automatic logic [31:0] branchInstr(input armPkg::condT cond, input logic [23:0] off);
    return {cond, armPkg::opBranch, 2'b10, off};
  endfunction

  // Immediate value as imm8 rotated right by 2*rot
  function automatic logic [31:0] rotValue(input logic [7:0] imm, input logic [3:0] rot);
    int s;
    logic [31:0] x;
    s = {27'h0, rot, 1'b0};
    x = {24'h0, imm};
    return (s == 0) ? x : ((x >> s) | (x << (32 - s)));
  endfunction

  task automatic emit(input logic [31:0] w);
    imem[progLen] = w;
    progLen = progLen + 8'd1;
  endtask

  // Branch to itself keeps the core parked
  task automatic endProgram();
    emit(branchInstr(armPkg::condAl, 24'hFF_FFFE));
  endtask

  // Builds any word byte by byte with MOV and ORR
  task automatic loadWord(input logic [3:0] rd, input logic [31:0] w);
    emit(dataImm(armPkg::condAl, armPkg::cmdMov, rd, 4'd0, 4'd0, w[7:0]));
    emit(dataImm(armPkg::condAl, armPkg::cmdOrr, rd, rd, 4'd12, w[15:8]));
    emit(dataImm(armPkg::condAl, armPkg::cmdOrr, rd, rd, 4'd8, w[23:16]));
    emit(dataImm(armPkg::condAl, armPkg::cmdOrr, rd, rd, 4'd4, w[31:24]));
  endtask

  task automatic clearProgram();
    int i;
    // Never-executing ADD whose immediate is the word index
    for (i = 0; i < 256; i++) begin
      imem[8'(i)] = {4'hF, armPkg::opData, 1'b1, armPkg::cmdAdd, 1'b0, 8'h11, 4'h0, 8'(i)};
    end
    progLen = 8'd0;
  endtask

  task automatic holdReset();
    @(negedge clk);
    rstN = 1'b0;
    clearProgram();
    expAddr.delete();
    expData.delete();
  endtask

  task automatic releaseReset();
    repeat (4) @(negedge clk);
    rstN = 1'b1;
  endtask

  task automatic expectStore(input logic [31:0] addr, input logic [31:0] data);
    expAddr.push_back(addr);
    expData.push_back(data);
  endtask

  task automatic checkValue(input string name, input string what,
      input logic [31:0] expected, input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("** Error %s: %s expected %h, actual %h", name, what, expected, actual);
    end
  endtask

  task automatic waitStores(input string name, input int count);
    int cycles;
    cycles = 0;
    while (storeAddrQ.size() < count && cycles < storeTimeout) begin
      @(posedge clk);
      cycles++;
    end
    assert (storeAddrQ.size() >= count) else begin
      errors++;
      $display("%s: no store %0d after %0d cycles, the core seems stuck",
               name, storeAddrQ.size() + 1, cycles);
    end
  endtask

  // Extra cycles catch stores that should never happen
  task automatic checkStores(input string name);
    int n;
    int i;
    n = expAddr.size();
    waitStores(name, n);
    repeat (16) @(posedge clk);
    checkValue(name, "store count", 32'(n), 32'(storeAddrQ.size()));
    for (i = 0; i < n && i < storeAddrQ.size(); i++) begin
      checkValue(name, $sformatf("store %0d address", i), expAddr[i], storeAddrQ[i]);
      checkValue(name, $sformatf("store %0d data", i), expData[i], storeDataQ[i]);
    end
  endtask

  task automatic resetTest();
    int startCycle;
    logic [7:0] v;
    v = 8'($urandom);
    holdReset();
    emit(dataImm(armPkg::condAl, armPkg::cmdMov, 4'd0, 4'd0, 4'd0, 8'h00));
    emit(dataImm(armPkg::condAl, armPkg::cmdMov, 4'd1, 4'd0, 4'd0, v));
    emit(memInstr(1'b0, 4'd1, 4'd0, 12'h040));
    endProgram();
    expectStore(32'h40, {24'h0, v});
    releaseReset();
    checkValue("resetTest", "first fetch address", armPkg::resetPc, instrAddr);
    checkValue("resetTest", "memWrite at release", 32'h0, {31'h0, memWrite});
    @(posedge clk);
    startCycle = cycleNum;
    checkStores("resetTest");
    // STR fetched in cycle 2 reaches Memory in cycle 5
    if (storeCycleQ.size() > 0) begin
      checkValue("resetTest", "first store cycle", 32'd5, 32'(storeCycleQ[0] - startCycle));
    end
  endtask

  task automatic aluChainTest();
    logic [7:0] imm [5];
    logic [3:0] rot [5];
    logic [31:0] m1, m2, m3;
    int i;
    holdReset();
    for (i = 0; i < 5; i++) begin
      imm[i] = 8'($urandom);
      rot[i] = 4'($urandom);
    end
    emit(dataImm(armPkg::condAl, armPkg::cmdMov, 4'd0, 4'd0, 4'd0, 8'h00));
    emit(dataImm(armPkg::condAl, armPkg::cmdMov, 4'd1, 4'd0, rot[0], imm[0]));
    emit(dataImm(armPkg::condAl, armPkg::cmdAdd, 4'd1, 4'd1, rot[1], imm[1]));
    emit(memInstr(1'b0, 4'd1, 4'd0, 12'h000));
    emit(dataImm(armPkg::condAl, armPkg::cmdSub, 4'd1, 4'd1, rot[2], imm[2]));
    emit(memInstr(1'b0, 4'd1, 4'd0, 12'h004));
    emit(dataImm(armPkg::condAl, armPkg::cmdAnd, 4'd1, 4'd1, rot[3], imm[3]));
    emit(memInstr(1'b0, 4'd1, 4'd0, 12'h008));
    emit(dataImm(armPkg::condAl, armPkg::cmdOrr, 4'd1, 4'd1, rot[4], imm[4]));
    emit(dataReg(armPkg::condAl, armPkg::cmdAdd, 4'd2, 4'd1, 4'd1));
    emit(memInstr(1'b0, 4'd2, 4'd0, 12'h00C));
    emit(dataReg(armPkg::condAl, armPkg::cmdSub, 4'd3, 4'd1, 4'd2));
    emit(memInstr(1'b0, 4'd3, 4'd0, 12'h010));
    emit(dataReg(armPkg::condAl, armPkg::cmdMov, 4'd4, 4'd0, 4'd3));
    emit(memInstr(1'b0, 4'd4, 4'd0, 12'h014));
    endProgram();
    m1 = rotValue(imm[0], rot[0]) + rotValue(imm[1], rot[1]);
    expectStore(32'h00, m1);
    m1 = m1 - rotValue(imm[2], rot[2]);
    expectStore(32'h04, m1);
    m1 = m1 & rotValue(imm[3], rot[3]);
    expectStore(32'h08, m1);
    m1 = m1 | rotValue(imm[4], rot[4]);
    m2 = m1 + m1;
    expectStore(32'h0C, m2);
    m3 = m1 - m2;
    expectStore(32'h10, m3);
    expectStore(32'h14, m3);
    releaseReset();
    checkStores("aluChainTest");
  endtask

  task automatic loadUseTest();
    logic [31:0] w;
    logic [7:0] imm;
    logic [3:0] rot;
    w = $urandom;
    imm = 8'($urandom);
    rot = 4'($urandom);
    holdReset();
    emit(dataImm(armPkg::condAl, armPkg::cmdMov, 4'd0, 4'd0, 4'd0, 8'h00));
    loadWord(4'd1, w);
    emit(memInstr(1'b0, 4'd1, 4'd0, 12'h080));
    emit(memInstr(1'b1, 4'd2, 4'd0, 12'h080));
    // Consumer right behind the load
    emit(dataImm(armPkg::condAl, armPkg::cmdAdd, 4'd3, 4'd2, rot, imm));
    emit(memInstr(1'b0, 4'd3, 4'd0, 12'h084));
    emit(memInstr(1'b0, 4'd2, 4'd0, 12'h088));
    endProgram();
    expectStore(32'h80, w);
    expectStore(32'h84, w + rotValue(imm, rot));
    expectStore(32'h88, w);
    releaseReset();
    checkStores("loadUseTest");
  endtask

  task automatic branchTest();
    logic [31:0] a, b, base, marker, swap;
    logic [11:0] off;
    int k;
    holdReset();
    emit(dataImm(armPkg::condAl, armPkg::cmdMov, 4'd0, 4'd0, 4'd0, 8'h00));
    for (k = 0; k < 4; k++) begin
      a = $urandom;
      b = (k == 0) ? a : $urandom;
      // Third round has a below b and the fourth has a above b
      if ((k == 2 && $signed(a) > $signed(b)) || (k == 3 && $signed(a) < $signed(b))) begin
        swap = a;
        a = b;
        b = swap;
      end
      off = 12'h100 + 12'(k) * 12'h020;
      base = {20'h0, off};
      marker = 32'(k + 16);
      loadWord(4'd1, a);
      loadWord(4'd2, b);
      emit(dataImm(armPkg::condAl, armPkg::cmdMov, 4'd5, 4'd0, 4'd0, marker[7:0]));
      emit(dataReg(armPkg::condAl, armPkg::cmdCmp, 4'd0, 4'd1, 4'd2));
      // Each branch with offset 0 hops over the one store behind it
      emit(branchInstr(armPkg::condEq, 24'h0));
      emit(memInstr(1'b0, 4'd5, 4'd0, off));
      emit(branchInstr(armPkg::condNe, 24'h0));
      emit(memInstr(1'b0, 4'd5, 4'd0, off + 12'd4));
      emit(branchInstr(armPkg::condLt, 24'h0));
      emit(memInstr(1'b0, 4'd5, 4'd0, off + 12'd8));
      emit(branchInstr(armPkg::condGe, 24'h0));
      emit(memInstr(1'b0, 4'd5, 4'd0, off + 12'd12));
      emit(memInstr(1'b0, 4'd5, 4'd0, off + 12'd16));
      if (a != b) expectStore(base, marker);
      if (a == b) expectStore(base + 32'd4, marker);
      if (!($signed(a) < $signed(b))) expectStore(base + 32'd8, marker);
      if ($signed(a) < $signed(b)) expectStore(base + 32'd12, marker);
      expectStore(base + 32'd16, marker);
    end
    endProgram();
    releaseReset();
    checkStores("branchTest");
  endtask

  task automatic condExecTest();
    logic [7:0] v;
    logic [31:0] strNe;
    v = 8'($urandom);
    holdReset();
    emit(dataImm(armPkg::condAl, armPkg::cmdMov, 4'd0, 4'd0, 4'd0, 8'h00));
    emit(dataImm(armPkg::condAl, armPkg::cmdMov, 4'd1, 4'd0, 4'd0, v));
    emit(dataImm(armPkg::condAl, armPkg::cmdMov, 4'd2, 4'd0, 4'd0, 8'h07));
    emit(dataImm(armPkg::condAl, armPkg::cmdMov, 4'd3, 4'd0, 4'd0, 8'h07));
    emit(dataReg(armPkg::condAl, armPkg::cmdCmp, 4'd0, 4'd2, 4'd3));
    emit(dataImm(armPkg::condNe, armPkg::cmdAdd, 4'd1, 4'd1, 4'd0, 8'h01));
    emit(dataImm(armPkg::condEq, armPkg::cmdAdd, 4'd6, 4'd1, 4'd0, 8'h02));
    // STRNE after an equal compare must not store
    strNe = memInstr(1'b0, 4'd1, 4'd0, 12'h208);
    strNe[31:28] = armPkg::condNe;
    emit(strNe);
    emit(memInstr(1'b0, 4'd1, 4'd0, 12'h200));
    emit(memInstr(1'b0, 4'd6, 4'd0, 12'h204));
    endProgram();
    expectStore(32'h200, {24'h0, v});
    expectStore(32'h204, {24'h0, v} + 32'd2);
    releaseReset();
    checkStores("condExecTest");
  endtask

  initial begin
    void'($urandom(32'h4c9e9cf8));
    rstN = 1'b0;
    clearProgram();
    resetTest();
    aluChainTest();
    loadUseTest();
    branchTest();
    condExecTest();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
